// ==== sim.f ====
src/hci_reg_pkg.sv
src/hci_queue_pkg.sv
src/hci_queue.sv
src/hci_cmd_assembler.sv
src/hci_csr.sv
src/hci_top.sv
tb/tb_hci_top.sv

// ==== Bender.yml ====
package:
  name: hci_pio

sources:
  - files:
      - src/hci_reg_pkg.sv
      - src/hci_queue_pkg.sv
      - src/hci_queue.sv
      - src/hci_cmd_assembler.sv
      - src/hci_csr.sv
      - src/hci_top.sv
  - target: test
    files:
      - tb/tb_hci_top.sv

// ==== tb/tb_hci_top.sv ====
// Testbench for the HCI PIO command and response path
// Drives the CPU port and both queue sides, checks against queue models
`timescale 1ns/1ns
`default_nettype none

module tb_hci_top;

  // CPU reads and writes over all six tests
  localparam int unsigned CPU_OPS = 2 + 40 + 7 + 3 * 26 + 19 + 15;
  localparam int unsigned WATCHDOG_CYCLES = CPU_OPS * 40 + 500;

  logic                            clk_i = 1'b0;
  logic                            rst_ni, cpu_req_i, cpu_req_is_wr_i;
  logic [hci_reg_pkg::ADDR_W-1:0]  cpu_addr_i;
  logic [hci_reg_pkg::DATA_W-1:0]  cpu_wr_data_i, cpu_rd_data_o;
  logic                            cpu_rd_ack_o, cpu_rd_err_o, cpu_wr_ack_o, cpu_wr_err_o;
  logic                            cmd_rvalid_o, cmd_rready_i, resp_wvalid_i, resp_wready_o;
  logic                            cmd_thld_trig_o, resp_thld_trig_o;
  hci_queue_pkg::hci_cmd_t         cmd_rdata_o;
  hci_queue_pkg::hci_resp_t        resp_wdata_i;

  hci_queue_pkg::hci_cmd_t         cmd_model[$];  // Commands still to come out
  hci_queue_pkg::hci_resp_t        resp_model[$];
  integer                          seed = 80;
  int                              errors = 0;
  int                              tests_run = 0;
  int                              tests_failed = 0;
  int                              test_start = 0;
  bit                              rready_random = 1'b0;

  hci_top i_hci_top (.*);

  always #2 clk_i = ~clk_i;

  // Random back-pressure with ready three cycles out of four
  always @(posedge clk_i) begin
    if (rready_random) cmd_rready_i <= ($random(seed) % 4) != 0;
  end

  task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp, got);
    errors++;
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t ns: %s", $time, what);
    errors++;
  endtask

  // Effective threshold as the raw value clamped into 1..QUEUE_DEPTH
  function automatic int eff_thld(input int raw);
    if (raw == 0) return 1;
    if (raw > hci_queue_pkg::QUEUE_DEPTH) return hci_queue_pkg::QUEUE_DEPTH;
    return raw;
  endfunction

  function automatic bit expected_trig(input int raw, input int used, input bit count_free);
    int level;
    level = count_free ? int'(hci_queue_pkg::QUEUE_DEPTH) - used : used;
    return level >= eff_thld(raw);
  endfunction

  // A transfer happens at the next rising edge
  always @(negedge clk_i) begin : compare_cmds
    hci_queue_pkg::hci_cmd_t exp_cmd;
    if (rst_ni && cmd_rvalid_o && cmd_rready_i) begin
      if (cmd_model.size() == 0) begin
        report_error("cmd_rdata_o delivered a command that was never written");
      end else begin
        exp_cmd = cmd_model.pop_front();
        if (cmd_rdata_o !== exp_cmd) report_mismatch("cmd_rdata_o", exp_cmd, cmd_rdata_o);
      end
    end
  end

  task automatic cpu_access(input bit wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited = 0;
    @(posedge clk_i);
    cpu_req_i       <= 1'b1;
    cpu_req_is_wr_i <= wr;
    cpu_addr_i      <= addr;
    cpu_wr_data_i   <= wdata;
    @(posedge clk_i);
    cpu_req_i <= 1'b0;
    @(negedge clk_i);
    while (!(wr ? cpu_wr_ack_o : cpu_rd_ack_o) && waited < 4) begin
      @(negedge clk_i);
      waited++;
    end
    if (!(wr ? cpu_wr_ack_o : cpu_rd_ack_o)) begin
      report_error("CPU access was never acknowledged");
    end else if (waited != 0) begin
      report_error("CPU acknowledge came later than one cycle after the request");
    end
    rdata = cpu_rd_data_o;
    err   = wr ? cpu_wr_err_o : cpu_rd_err_o;
  endtask

  task automatic cpu_write(input logic [7:0] addr, input logic [31:0] data, input bit exp_err);
    logic [31:0] rdata;
    logic        err;
    cpu_access(1'b1, addr, data, rdata, err);
    if (err !== exp_err) report_mismatch("cpu_wr_err_o", exp_err, err);
  endtask

  task automatic cpu_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    cpu_access(1'b0, addr, '0, data, err);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input bit exp_err);
    logic [31:0] data;
    logic        err;
    cpu_read(addr, data, err);
    if (err !== exp_err) report_mismatch("cpu_rd_err_o", exp_err, err);
    if (data !== exp) report_mismatch("cpu_rd_data_o", exp, data);
  endtask

  // Low dword first so the command lands on the second write
  task automatic write_cmd(input hci_queue_pkg::hci_cmd_t cmd, input bit exp_drop);
    cpu_write(hci_reg_pkg::ADDR_COMMAND_PORT, cmd[31:0], 1'b0);
    if (!exp_drop) cmd_model.push_back(cmd);
    cpu_write(hci_reg_pkg::ADDR_COMMAND_PORT, cmd[63:32], exp_drop);
  endtask

  task automatic push_resp(input hci_queue_pkg::hci_resp_t data);
    @(posedge clk_i);
    resp_wvalid_i <= 1'b1;
    resp_wdata_i  <= data;
    @(negedge clk_i);
    while (!resp_wready_o) @(negedge clk_i);
    @(posedge clk_i);
    resp_wvalid_i <= 1'b0;
    resp_model.push_back(data);
  endtask

  task automatic drain_resps;
    while (resp_model.size() != 0) begin
      read_expect(hci_reg_pkg::ADDR_RESPONSE_PORT, resp_model.pop_front(), 1'b0);
    end
  endtask

  task automatic set_rready(input bit random_mode, input bit level);
    @(negedge clk_i);
    rready_random = random_mode;
    @(posedge clk_i);
    if (!random_mode) cmd_rready_i <= level;
  endtask

  task automatic wait_cmds_out;
    int n = 0;
    while (cmd_model.size() != 0 && n < 300) begin
      @(posedge clk_i);
      n++;
    end
    if (cmd_model.size() != 0) report_error("expected commands never left the command queue");
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_start) tests_failed++;
    $display("Test %0d %s: %s", tests_run, name, (errors == test_start) ? "pass" : "FAIL");
    test_start = errors;
  endtask

  initial begin : stimulus
    int          raw_vals[3] = '{0, 3, 200};
    logic [7:0]  cmd_raw, resp_raw, cmd_eff, resp_eff;
    logic [31:0] data;
    logic        err;
    int          polls;
    rst_ni          = 1'b0;
    cpu_req_i       = 1'b0;
    cpu_req_is_wr_i = 1'b0;
    cpu_addr_i      = '0;
    cpu_wr_data_i   = '0;
    cmd_rready_i    = 1'b0;
    resp_wvalid_i   = 1'b0;
    resp_wdata_i    = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    if (cmd_thld_trig_o !== 1'b1) report_mismatch("cmd_thld_trig_o", 1, cmd_thld_trig_o);
    if (resp_thld_trig_o !== 1'b0) report_mismatch("resp_thld_trig_o", 0, resp_thld_trig_o);
    if (cmd_rvalid_o !== 1'b0) report_mismatch("cmd_rvalid_o", 0, cmd_rvalid_o);
    if (resp_wready_o !== 1'b1) report_mismatch("resp_wready_o", 1, resp_wready_o);
    read_expect(hci_reg_pkg::ADDR_HC_VERSION, 32'h120, 1'b0);
    read_expect(8'h40, 32'h0, 1'b1); // Unmapped
    finish_test("after reset");

    set_rready(1'b1, 1'b0);
    for (int i = 0; i < 20; i++) write_cmd({$random(seed), $random(seed)}, 1'b0);
    wait_cmds_out();
    set_rready(1'b0, 1'b0);
    finish_test("commands");

    for (int i = 0; i < 6; i++) push_resp($random(seed));
    drain_resps();
    read_expect(hci_reg_pkg::ADDR_RESPONSE_PORT, 32'h0, 1'b1); // Queue now empty
    finish_test("responses");

    foreach (raw_vals[j]) begin
      cmd_raw  = raw_vals[j];
      resp_raw = raw_vals[(j + 1) % 3]; // Differs from the command field
      cmd_eff  = eff_thld(cmd_raw);
      resp_eff = eff_thld(resp_raw);
      cpu_write(hci_reg_pkg::ADDR_QUEUE_THLD_CTRL, {16'h0, resp_raw, cmd_raw}, 1'b0);
      read_expect(hci_reg_pkg::ADDR_QUEUE_THLD_CTRL, {16'h0, resp_eff, cmd_eff}, 1'b0);
      for (int k = 0; k <= 8; k++) begin
        if (k > 0) begin
          write_cmd({$random(seed), $random(seed)}, 1'b0);
          push_resp($random(seed));
        end
        repeat (3) @(posedge clk_i); // Trigger lags the count
        @(negedge clk_i);
        if (cmd_thld_trig_o !== expected_trig(cmd_raw, k, 1'b1))
          report_mismatch("cmd_thld_trig_o", expected_trig(cmd_raw, k, 1'b1),
                          cmd_thld_trig_o);
        if (resp_thld_trig_o !== expected_trig(resp_raw, k, 1'b0))
          report_mismatch("resp_thld_trig_o", expected_trig(resp_raw, k, 1'b0),
                          resp_thld_trig_o);
      end
      set_rready(1'b0, 1'b1);
      wait_cmds_out();
      set_rready(1'b0, 1'b0);
      drain_resps();
    end
    finish_test("thresholds");

    for (int i = 0; i < 9; i++) write_cmd({$random(seed), $random(seed)}, i == 8);
    read_expect(hci_reg_pkg::ADDR_QUEUE_STATUS, 32'h6, 1'b0); // Cmd full, resp empty
    set_rready(1'b0, 1'b1);
    wait_cmds_out();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    if (cmd_rvalid_o !== 1'b0) report_mismatch("cmd_rvalid_o", 0, cmd_rvalid_o);
    set_rready(1'b0, 1'b0);
    finish_test("overflow");

    for (int i = 0; i < 3; i++) begin
      write_cmd({$random(seed), $random(seed)}, 1'b0);
      push_resp($random(seed));
    end
    cpu_write(hci_reg_pkg::ADDR_COMMAND_PORT, $random(seed), 1'b0); // Stale half command
    cpu_write(hci_reg_pkg::ADDR_RESET_CONTROL, 32'h6, 1'b0);
    cmd_model.delete();
    resp_model.delete();
    polls = 0;
    do begin
      cpu_read(hci_reg_pkg::ADDR_RESET_CONTROL, data, err);
      polls++;
    end while ((data & 32'h6) != 0 && polls < 20);
    if ((data & 32'h6) != 0) report_error("RESET_CONTROL bits never cleared");
    read_expect(hci_reg_pkg::ADDR_QUEUE_STATUS, 32'h5, 1'b0); // Both queues empty
    write_cmd({$random(seed), $random(seed)}, 1'b0);
    set_rready(1'b0, 1'b1);
    wait_cmds_out();
    read_expect(hci_reg_pkg::ADDR_RESPONSE_PORT, 32'h0, 1'b1);
    finish_test("soft reset");

    $display("Tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Error: watchdog expired after %0d cycles, the tests did not complete",
             WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/hci_top.sv ====
// HCI PIO top level
// Register block, command assembler, command queue and response queue
`timescale 1ns/1ns
`default_nettype none

module hci_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  input  logic                            cpu_req_i,
  input  logic                            cpu_req_is_wr_i,
  input  logic [hci_reg_pkg::ADDR_W-1:0]  cpu_addr_i,
  input  logic [hci_reg_pkg::DATA_W-1:0]  cpu_wr_data_i,
  output logic                            cpu_rd_ack_o,
  output logic                            cpu_rd_err_o,
  output logic [hci_reg_pkg::DATA_W-1:0]  cpu_rd_data_o,
  output logic                            cpu_wr_ack_o,
  output logic                            cpu_wr_err_o,

  output logic                            cmd_rvalid_o,
  input  logic                            cmd_rready_i,
  output hci_queue_pkg::hci_cmd_t         cmd_rdata_o,

  input  logic                            resp_wvalid_i,
  output logic                            resp_wready_o,
  input  hci_queue_pkg::hci_resp_t        resp_wdata_i,

  output logic                            cmd_thld_trig_o,
  output logic                            resp_thld_trig_o
);

  // Register block to command path
  logic                             cmd_word_valid;
  logic [hci_reg_pkg::DATA_W-1:0]   cmd_word;
  logic                             cmd_drop;
  logic                             cmd_wvalid, cmd_wready;
  hci_queue_pkg::hci_cmd_t          cmd_wdata;
  logic [hci_queue_pkg::THLD_W-1:0] cmd_thld, cmd_thld_eff;
  logic                             cmd_rst, cmd_rst_done;
  logic                             cmd_empty, cmd_full;

  // Response path to register block
  logic                             resp_rvalid, resp_rready;
  hci_queue_pkg::hci_resp_t         resp_rdata;
  logic [hci_queue_pkg::THLD_W-1:0] resp_thld, resp_thld_eff;
  logic                             resp_rst, resp_rst_done;
  logic                             resp_empty, resp_full;

  hci_csr i_csr (
    .clk_i,
    .rst_ni,
    .cpu_req_i,
    .cpu_req_is_wr_i,
    .cpu_addr_i,
    .cpu_wr_data_i,
    .cpu_rd_ack_o,
    .cpu_rd_err_o,
    .cpu_rd_data_o,
    .cpu_wr_ack_o,
    .cpu_wr_err_o,
    .cmd_drop_i       (cmd_drop),
    .cmd_empty_i      (cmd_empty),
    .cmd_full_i       (cmd_full),
    .cmd_thld_eff_i   (cmd_thld_eff),
    .cmd_rst_done_i   (cmd_rst_done),
    .cmd_word_valid_o (cmd_word_valid),
    .cmd_word_o       (cmd_word),
    .cmd_thld_o       (cmd_thld),
    .cmd_rst_o        (cmd_rst),
    .resp_rvalid_i    (resp_rvalid),
    .resp_rdata_i     (resp_rdata),
    .resp_empty_i     (resp_empty),
    .resp_full_i      (resp_full),
    .resp_thld_eff_i  (resp_thld_eff),
    .resp_rst_done_i  (resp_rst_done),
    .resp_rready_o    (resp_rready),
    .resp_thld_o      (resp_thld),
    .resp_rst_o       (resp_rst)
  );

  hci_cmd_assembler i_cmd_asm (
    .clk_i,
    .rst_ni,
    .word_valid_i (cmd_word_valid),
    .word_i       (cmd_word),
    .flush_i      (cmd_rst), // Soft reset also drops a half command
    .wready_i     (cmd_wready),
    .wvalid_o     (cmd_wvalid),
    .wdata_o      (cmd_wdata),
    .cmd_drop_o   (cmd_drop)
  );

  hci_queue #(
    .payload_t (hci_queue_pkg::hci_cmd_t),
    .CountFree (1'b1)
  ) i_cmd_queue (
    .clk_i,
    .rst_ni,
    .wvalid_i        (cmd_wvalid),
    .wready_o        (cmd_wready),
    .wdata_i         (cmd_wdata),
    .rvalid_o        (cmd_rvalid_o),
    .rready_i        (cmd_rready_i),
    .rdata_o         (cmd_rdata_o),
    .thld_i          (cmd_thld),
    .thld_eff_o      (cmd_thld_eff),
    .thld_trig_o     (cmd_thld_trig_o),
    .empty_o         (cmd_empty),
    .full_o          (cmd_full),
    .soft_rst_i      (cmd_rst),
    .soft_rst_done_o (cmd_rst_done)
  );

  hci_queue #(
    .payload_t (hci_queue_pkg::hci_resp_t),
    .CountFree (1'b0)
  ) i_resp_queue (
    .clk_i,
    .rst_ni,
    .wvalid_i        (resp_wvalid_i),
    .wready_o        (resp_wready_o),
    .wdata_i         (resp_wdata_i),
    .rvalid_o        (resp_rvalid),
    .rready_i        (resp_rready),
    .rdata_o         (resp_rdata),
    .thld_i          (resp_thld),
    .thld_eff_o      (resp_thld_eff),
    .thld_trig_o     (resp_thld_trig_o),
    .empty_o         (resp_empty),
    .full_o          (resp_full),
    .soft_rst_i      (resp_rst),
    .soft_rst_done_o (resp_rst_done)
  );

endmodule

`default_nettype wire

// ==== src/hci_csr.sv ====
// HCI register block
// Decodes CPU strobes, holds thresholds and reset bits, drives the queue ports
`timescale 1ns/1ns
`default_nettype none

module hci_csr (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  logic                                cpu_req_i,
  input  logic                                cpu_req_is_wr_i,
  input  logic [hci_reg_pkg::ADDR_W-1:0]      cpu_addr_i,
  input  logic [hci_reg_pkg::DATA_W-1:0]      cpu_wr_data_i,
  output logic                                cpu_rd_ack_o,
  output logic                                cpu_rd_err_o,
  output logic [hci_reg_pkg::DATA_W-1:0]      cpu_rd_data_o,
  output logic                                cpu_wr_ack_o,
  output logic                                cpu_wr_err_o,

  input  logic                                cmd_drop_i,
  input  logic                                cmd_empty_i,
  input  logic                                cmd_full_i,
  input  logic [hci_queue_pkg::THLD_W-1:0]    cmd_thld_eff_i,
  input  logic                                cmd_rst_done_i,
  output logic                                cmd_word_valid_o,
  output logic [hci_reg_pkg::DATA_W-1:0]      cmd_word_o,
  output logic [hci_queue_pkg::THLD_W-1:0]    cmd_thld_o,
  output logic                                cmd_rst_o,

  input  logic                                resp_rvalid_i,
  input  hci_queue_pkg::hci_resp_t            resp_rdata_i,
  input  logic                                resp_empty_i,
  input  logic                                resp_full_i,
  input  logic [hci_queue_pkg::THLD_W-1:0]    resp_thld_eff_i,
  input  logic                                resp_rst_done_i,
  output logic                                resp_rready_o,
  output logic [hci_queue_pkg::THLD_W-1:0]    resp_thld_o,
  output logic                                resp_rst_o
);

  logic                               wr_req, rd_req;
  logic                               rd_err_d;
  logic [hci_reg_pkg::DATA_W-1:0]     rd_data_d, rd_data_q;
  logic                               rd_ack_q, rd_err_q, wr_ack_q, wr_err_q;
  logic [hci_queue_pkg::THLD_W-1:0]   cmd_thld_q, resp_thld_q;
  logic                               cmd_rst_q, resp_rst_q;

  assign wr_req = cpu_req_i & cpu_req_is_wr_i;
  assign rd_req = cpu_req_i & ~cpu_req_is_wr_i;

  // Port strobes go straight out in the request cycle
  assign cmd_word_valid_o = wr_req && (cpu_addr_i == hci_reg_pkg::ADDR_COMMAND_PORT);
  assign cmd_word_o       = cpu_wr_data_i;
  assign resp_rready_o    = rd_req && (cpu_addr_i == hci_reg_pkg::ADDR_RESPONSE_PORT);

  // Read mux, errored reads return zero
  always_comb begin
    rd_data_d = '0;
    rd_err_d  = 1'b0;
    case (cpu_addr_i)
      hci_reg_pkg::ADDR_HC_VERSION: rd_data_d = hci_reg_pkg::VERSION_VALUE;
      hci_reg_pkg::ADDR_RESET_CONTROL: begin
        rd_data_d[hci_reg_pkg::CMD_RST_BIT]  = cmd_rst_q;
        rd_data_d[hci_reg_pkg::RESP_RST_BIT] = resp_rst_q;
      end
      hci_reg_pkg::ADDR_QUEUE_THLD_CTRL: begin
        // Effective values, as clamped by the queues
        rd_data_d[hci_reg_pkg::CMD_THLD_LSB +: hci_queue_pkg::THLD_W]  = cmd_thld_eff_i;
        rd_data_d[hci_reg_pkg::RESP_THLD_LSB +: hci_queue_pkg::THLD_W] = resp_thld_eff_i;
      end
      hci_reg_pkg::ADDR_COMMAND_PORT: rd_data_d = '0; // Write-only
      hci_reg_pkg::ADDR_RESPONSE_PORT: begin
        if (resp_rvalid_i) begin
          rd_data_d = resp_rdata_i;
        end else begin
          rd_err_d = 1'b1; // Queue empty
        end
      end
      hci_reg_pkg::ADDR_QUEUE_STATUS: begin
        rd_data_d[hci_reg_pkg::STATUS_CMD_EMPTY_BIT]  = cmd_empty_i;
        rd_data_d[hci_reg_pkg::STATUS_CMD_FULL_BIT]   = cmd_full_i;
        rd_data_d[hci_reg_pkg::STATUS_RESP_EMPTY_BIT] = resp_empty_i;
        rd_data_d[hci_reg_pkg::STATUS_RESP_FULL_BIT]  = resp_full_i;
      end
      default: rd_err_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q    <= 1'b0;
      rd_err_q    <= 1'b0;
      wr_ack_q    <= 1'b0;
      wr_err_q    <= 1'b0;
      cmd_thld_q  <= '0;
      resp_thld_q <= '0;
      cmd_rst_q   <= 1'b0;
      resp_rst_q  <= 1'b0;
    end else begin
      rd_ack_q <= rd_req;
      rd_err_q <= rd_req & rd_err_d;
      wr_ack_q <= wr_req;
      wr_err_q <= cmd_word_valid_o & cmd_drop_i; // Completed command hit a full queue

      // HW clears a reset bit once its queue reports the flush
      if (cmd_rst_done_i) cmd_rst_q <= 1'b0;
      if (resp_rst_done_i) resp_rst_q <= 1'b0;

      if (wr_req && (cpu_addr_i == hci_reg_pkg::ADDR_RESET_CONTROL)) begin
        if (cpu_wr_data_i[hci_reg_pkg::CMD_RST_BIT]) cmd_rst_q <= 1'b1;
        if (cpu_wr_data_i[hci_reg_pkg::RESP_RST_BIT]) resp_rst_q <= 1'b1;
      end

      if (wr_req && (cpu_addr_i == hci_reg_pkg::ADDR_QUEUE_THLD_CTRL)) begin
        cmd_thld_q  <= cpu_wr_data_i[hci_reg_pkg::CMD_THLD_LSB +: hci_queue_pkg::THLD_W];
        resp_thld_q <= cpu_wr_data_i[hci_reg_pkg::RESP_THLD_LSB +: hci_queue_pkg::THLD_W];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) rd_data_q <= rd_data_d;
  end

  assign cpu_rd_ack_o  = rd_ack_q;
  assign cpu_rd_err_o  = rd_err_q;
  assign cpu_rd_data_o = rd_data_q;
  assign cpu_wr_ack_o  = wr_ack_q;
  assign cpu_wr_err_o  = wr_err_q;

  assign cmd_thld_o  = cmd_thld_q;
  assign resp_thld_o = resp_thld_q;
  assign cmd_rst_o   = cmd_rst_q;
  assign resp_rst_o  = resp_rst_q;

  // One request per cycle yields at most one kind of ack
  a_single_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cpu_rd_ack_o && cpu_wr_ack_o));

endmodule

`default_nettype wire

// ==== src/hci_cmd_assembler.sv ====
// Command assembler
// Joins two COMMAND_PORT dwords into one command for the command queue
`timescale 1ns/1ns
`default_nettype none

module hci_cmd_assembler (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            word_valid_i,
  input  logic [hci_reg_pkg::DATA_W-1:0]  word_i,
  input  logic                            flush_i,
  input  logic                            wready_i,
  output logic                            wvalid_o,
  output hci_queue_pkg::hci_cmd_t         wdata_o,
  output logic                            cmd_drop_o
);

  logic                            phase_q; // High once the low dword is held
  logic [hci_reg_pkg::DATA_W-1:0]  low_q;
  logic                            second_word;

  assign second_word = word_valid_i & phase_q;

  // Push only into a queue with room, otherwise flag the drop
  assign wvalid_o   = second_word & wready_i;
  assign cmd_drop_o = second_word & ~wready_i;
  assign wdata_o    = {word_i, low_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 1'b0;
    end else if (flush_i) begin
      phase_q <= 1'b0; // Forget any half command
    end else if (word_valid_i) begin
      phase_q <= ~phase_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_valid_i && !phase_q) low_q <= word_i;
  end

  a_push_has_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid_o |-> wready_i);

endmodule

`default_nettype wire

// ==== src/hci_queue.sv ====
// Generic HCI queue
// Circular FIFO with clamped threshold, registered trigger and soft-reset flush
`timescale 1ns/1ns
`default_nettype none

module hci_queue #(
  parameter type payload_t = logic [31:0],
  parameter bit  CountFree = 1'b0 // Trigger on free entries instead of used ones
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              wvalid_i,
  output logic                              wready_o,
  input  payload_t                          wdata_i,
  output logic                              rvalid_o,
  input  logic                              rready_i,
  output payload_t                          rdata_o,
  input  logic [hci_queue_pkg::THLD_W-1:0]  thld_i,
  output logic [hci_queue_pkg::THLD_W-1:0]  thld_eff_o,
  output logic                              thld_trig_o,
  output logic                              empty_o,
  output logic                              full_o,
  input  logic                              soft_rst_i,
  output logic                              soft_rst_done_o
);

  payload_t                                mem [hci_queue_pkg::QUEUE_DEPTH];
  logic [hci_queue_pkg::CNT_W-2:0]         wptr_q, rptr_q; // Wrap at depth
  logic [hci_queue_pkg::CNT_W-1:0]         count_q;
  logic                                    push, pop;
  logic [hci_queue_pkg::THLD_W-1:0]        level;
  logic                                    trig_q;
  logic                                    done_q;

  assign full_o   = (count_q == hci_queue_pkg::CNT_W'(hci_queue_pkg::QUEUE_DEPTH));
  assign empty_o  = (count_q == '0);
  assign wready_o = ~full_o;
  assign rvalid_o = ~empty_o;
  assign rdata_o  = mem[rptr_q];

  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  // Clamp raw threshold into 1..QUEUE_DEPTH
  always_comb begin
    if (thld_i == '0) begin
      thld_eff_o = hci_queue_pkg::THLD_W'(1);
    end else if (thld_i > hci_queue_pkg::THLD_W'(hci_queue_pkg::QUEUE_DEPTH)) begin
      thld_eff_o = hci_queue_pkg::THLD_W'(hci_queue_pkg::QUEUE_DEPTH);
    end else begin
      thld_eff_o = thld_i;
    end
  end

  // Free or used entries, depending on the queue direction
  assign level = CountFree
    ? hci_queue_pkg::THLD_W'(hci_queue_pkg::CNT_W'(hci_queue_pkg::QUEUE_DEPTH) - count_q)
    : hci_queue_pkg::THLD_W'(count_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
      trig_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      trig_q <= (level >= thld_eff_o); // One cycle behind the count
      done_q <= soft_rst_i & ~done_q;  // Single pulse per request
      if (soft_rst_i) begin
        wptr_q  <= '0;
        rptr_q  <= '0;
        count_q <= '0;
      end else begin
        if (push) wptr_q <= wptr_q + 1'b1;
        if (pop) rptr_q <= rptr_q + 1'b1;
        case ({push, pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wptr_q] <= wdata_i;
  end

  assign thld_trig_o     = trig_q;
  assign soft_rst_done_o = done_q;

  a_count_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= hci_queue_pkg::CNT_W'(hci_queue_pkg::QUEUE_DEPTH));

endmodule

`default_nettype wire

// ==== src/hci_queue_pkg.sv ====
// HCI queue sizing and payload types
// Shared by the command and the response queue
`default_nettype none

package hci_queue_pkg;

  // Entries per queue, kept a power of two so pointers wrap on their own
  localparam int unsigned QUEUE_DEPTH = 8;

  // Width of a programmable threshold
  localparam int unsigned THLD_W = 8;

  // Occupancy count, must hold 0 up to QUEUE_DEPTH
  localparam int unsigned CNT_W = 4;

  // Command descriptor, assembled from two dwords
  typedef logic [63:0] hci_cmd_t;

  // Response descriptor, one dword
  typedef logic [31:0] hci_resp_t;

endpackage

`default_nettype wire

// ==== src/hci_reg_pkg.sv ====
// HCI register map for the PIO command and response path
// Addresses, field positions and CPU port widths
`default_nettype none

package hci_reg_pkg;

  // CPU port
  localparam int unsigned ADDR_W = 8;
  localparam int unsigned DATA_W = 32;

  // Register addresses, byte granular
  localparam logic [ADDR_W-1:0] ADDR_HC_VERSION      = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_RESET_CONTROL   = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_QUEUE_THLD_CTRL = 8'h08;
  localparam logic [ADDR_W-1:0] ADDR_COMMAND_PORT    = 8'h0C;
  localparam logic [ADDR_W-1:0] ADDR_RESPONSE_PORT   = 8'h10;
  localparam logic [ADDR_W-1:0] ADDR_QUEUE_STATUS    = 8'h14;

  localparam logic [DATA_W-1:0] VERSION_VALUE = 32'h0000_0120; // HCI 1.2

  // RESET_CONTROL bits, set by SW and cleared by HW
  localparam int unsigned CMD_RST_BIT  = 1;
  localparam int unsigned RESP_RST_BIT = 2;

  // QUEUE_THLD_CTRL field offsets
  localparam int unsigned CMD_THLD_LSB  = 0;
  localparam int unsigned RESP_THLD_LSB = 8;

  // QUEUE_STATUS bits
  localparam int unsigned STATUS_CMD_EMPTY_BIT  = 0;
  localparam int unsigned STATUS_CMD_FULL_BIT   = 1;
  localparam int unsigned STATUS_RESP_EMPTY_BIT = 2;
  localparam int unsigned STATUS_RESP_FULL_BIT  = 3;

endpackage

`default_nettype wire
